// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module anti_theft_tb -f tb.f \
   && ./obj_dir/Vanti_theft_tb > sim.log 2>&1 \
   || echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && echo "run failed" && exit 1
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "run failed"; exit 1; }
echo "run passed"
exit 0

// File: source/anti_theft_fsm.sv
`timescale 1ns/10ps

module anti_theft_fsm
(
   input  logic       clock_25mhz,
   input  logic       reset_sync,
   input  logic       ignition,
   input  logic       driver_door,
   input  logic       passenger_door,
   input  logic       reprogram,
   input  logic       expired,
   input  logic       second_tick,
   output logic       start_timer,
   output logic [1:0] interval,
   output logic       alarm,
   output logic       status_lamp
);

   import antitheft_pkg::*;

   theft_state_t state;
   theft_state_t next_state;
   lamp_mode_t   lamp_mode;
   logic         launch;
   logic [1:0]   launch_interval;
   logic         any_door;

   assign any_door = driver_door || passenger_door;

   ////////////////////////////////////////
   // next state and timer launch
   ////////////////////////////////////////
   always_comb
   begin
      next_state      = state;
      launch          = 1'b0;
      launch_interval = interval;
      if (ignition)
      begin
         // ignition wins over everything
         next_state = disarmed;
      end
      else
      begin
         case (state)
            armed:
            begin
               if (driver_door)
               begin
                  next_state      = triggered;
                  launch          = 1'b1;
                  launch_interval = INTERVAL_DRIVER_DELAY;
               end
               else if (passenger_door)
               begin
                  next_state      = triggered;
                  launch          = 1'b1;
                  launch_interval = INTERVAL_PASSENGER_DELAY;
               end
            end
            triggered:
               if (expired) next_state = sound_alarm;
            sound_alarm:
            begin
               if (!any_door)
               begin
                  next_state      = expiring_alarm;
                  launch          = 1'b1;
                  launch_interval = INTERVAL_ALARM_ON;
               end
            end
            expiring_alarm:
            begin
               if (expired)
                  next_state = armed;
               else if (any_door)
                  next_state = sound_alarm;
            end
            disarmed:
               next_state = disarmed_ignition_off;
            disarmed_ignition_off:
               if (driver_door) next_state = disarmed_door_open;
            disarmed_door_open:
            begin
               // driver has left and shut the door
               if (!driver_door)
               begin
                  next_state      = disarmed_arming;
                  launch          = 1'b1;
                  launch_interval = INTERVAL_ARM_DELAY;
               end
            end
            disarmed_arming:
            begin
               if (any_door)
                  next_state = disarmed;
               else if (expired)
                  next_state = armed;
            end
            default:
               next_state = armed;
         endcase
      end
   end

   // lamp mode of the state being entered
   always_comb
   begin
      case (next_state)
         armed:                                     lamp_mode = blinking;
         triggered, sound_alarm, expiring_alarm:    lamp_mode = steady;
         default:                                   lamp_mode = off;
      endcase
   end

   ////////////////////////////////////////
   // state and registered outputs
   ////////////////////////////////////////
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync || reprogram)
      begin
         state       <= armed;
         start_timer <= 1'b0;
         interval    <= INTERVAL_ARM_DELAY;
         alarm       <= 1'b0;
         status_lamp <= 1'b0;
      end
      else
      begin
         state       <= next_state;
         start_timer <= launch;
         if (launch)
            interval <= launch_interval;
         alarm <= (next_state == sound_alarm) || (next_state == expiring_alarm);
         case (lamp_mode)
            off:      status_lamp <= 1'b0;
            steady:   status_lamp <= 1'b1;
            default:
               // half period of one second
               if (second_tick) status_lamp <= !status_lamp;
         endcase
      end
   end

endmodule

// File: source/anti_theft_top.sv
`timescale 1ns/10ps

module anti_theft_top
#(
   parameter int TICKS_PER_SECOND = 25_000_000,
   parameter int DEBOUNCE_CYCLES  = 250_000
)
(
   input  logic                                 clock_25mhz,
   input  logic                                 reset_sync,
   input  logic                                 brake_button,
   input  logic                                 hidden_button,
   input  logic                                 driver_door_button,
   input  logic                                 passenger_door_button,
   input  logic                                 ignition_switch,
   input  logic                                 reprogram_button,
   input  logic [1:0]                           select_switches,
   input  logic [antitheft_pkg::TIME_WIDTH-1:0] value_switches,
   output logic                                 alarm,
   output logic                                 status_lamp,
   output logic                                 fuel_pump_power,
   output logic [antitheft_pkg::TIME_WIDTH-1:0] countdown
);

   import antitheft_pkg::*;

   logic [NUM_SWITCHES-1:0] raw_switches;
   logic [NUM_SWITCHES-1:0] synced_switches;
   logic [NUM_SWITCHES-1:0] clean_switches;
   logic                    start_timer;
   logic [1:0]              interval;
   logic [TIME_WIDTH-1:0]   selected_time;
   logic                    second_tick;
   logic                    expired;

   ////////////////////////////////////////
   // switch inputs
   ////////////////////////////////////////
   assign raw_switches[SW_BRAKE]                     = brake_button;
   assign raw_switches[SW_HIDDEN]                    = hidden_button;
   assign raw_switches[SW_DRIVER_DOOR]               = driver_door_button;
   assign raw_switches[SW_PASSENGER_DOOR]            = passenger_door_button;
   assign raw_switches[SW_IGNITION]                  = ignition_switch;
   assign raw_switches[SW_REPROGRAM]                 = reprogram_button;
   assign raw_switches[SW_SELECT_HI:SW_SELECT_LO]    = select_switches;
   assign raw_switches[SW_VALUE_LO +: TIME_WIDTH]    = value_switches;

   input_conditioner input_conditioner_inst (.clock_25mhz, .raw_switches, .synced_switches);

   // one debouncer per switch
   for (genvar i = 0; i < NUM_SWITCHES; i++)
   begin : g_debounce
      switch_debounce #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) switch_debounce_inst
      (
         .clock_25mhz, .reset_sync, .noisy(synced_switches[i]), .clean(clean_switches[i])
      );
   end

   ////////////////////////////////////////
   // timing and controllers
   ////////////////////////////////////////
   time_parameter_store time_parameter_store_inst
   (
      .clock_25mhz, .reset_sync, .reprogram(clean_switches[SW_REPROGRAM]),
      .select(clean_switches[SW_SELECT_HI:SW_SELECT_LO]),
      .new_value(clean_switches[SW_VALUE_LO +: TIME_WIDTH]), .interval, .selected_time
   );

   interval_timer #(.TICKS_PER_SECOND(TICKS_PER_SECOND)) interval_timer_inst
   (
      .clock_25mhz, .reset_sync, .start_timer, .load_value(selected_time),
      .second_tick, .expired, .countdown
   );

   anti_theft_fsm anti_theft_fsm_inst
   (
      .clock_25mhz, .reset_sync, .ignition(clean_switches[SW_IGNITION]),
      .driver_door(clean_switches[SW_DRIVER_DOOR]),
      .passenger_door(clean_switches[SW_PASSENGER_DOOR]),
      .reprogram(clean_switches[SW_REPROGRAM]), .expired, .second_tick,
      .start_timer, .interval, .alarm, .status_lamp
   );

   fuel_pump_fsm fuel_pump_fsm_inst
   (
      .clock_25mhz, .reset_sync, .ignition(clean_switches[SW_IGNITION]),
      .hidden_switch(clean_switches[SW_HIDDEN]), .brake(clean_switches[SW_BRAKE]),
      .fuel_pump_power
   );

endmodule

// File: source/antitheft_pkg.sv
package antitheft_pkg;

   ////////////////////////////////////////
   // switch vector layout
   ////////////////////////////////////////
   localparam int NUM_SWITCHES      = 12;
   localparam int SW_BRAKE          = 0;
   localparam int SW_HIDDEN         = 1;
   localparam int SW_DRIVER_DOOR    = 2;
   localparam int SW_PASSENGER_DOOR = 3;
   localparam int SW_IGNITION       = 4;
   localparam int SW_REPROGRAM      = 5;
   localparam int SW_SELECT_LO      = 6;
   localparam int SW_SELECT_HI      = 7;
   // value bits run upward from here
   localparam int SW_VALUE_LO       = 8;

   ////////////////////////////////////////
   // time parameters
   ////////////////////////////////////////
   localparam int TIME_WIDTH = 4;

   localparam logic [1:0] INTERVAL_ARM_DELAY       = 2'd0;
   localparam logic [1:0] INTERVAL_DRIVER_DELAY    = 2'd1;
   localparam logic [1:0] INTERVAL_PASSENGER_DELAY = 2'd2;
   localparam logic [1:0] INTERVAL_ALARM_ON        = 2'd3;

   // alarm on 10, passenger 15, driver 8, arm 6
   localparam logic [4*TIME_WIDTH-1:0] DEFAULT_PARAMETERS = 16'hAF86;

   // flat word for the reset load, fields indexed by selector code
   typedef union packed {
      logic [4*TIME_WIDTH-1:0]       word;
      logic [3:0][TIME_WIDTH-1:0]    field;
   } time_parameters_t;

   typedef enum logic [2:0] {
      armed, triggered, sound_alarm, expiring_alarm,
      disarmed, disarmed_ignition_off, disarmed_door_open, disarmed_arming
   } theft_state_t;

   typedef enum logic [1:0] {off, blinking, steady} lamp_mode_t;

   typedef enum logic [1:0] {pump_off, restore_start, restore, latch_on} fuel_state_t;

endpackage

// File: source/fuel_pump_fsm.sv
`timescale 1ns/10ps

module fuel_pump_fsm
(
   input  logic clock_25mhz,
   input  logic reset_sync,
   input  logic ignition,
   input  logic hidden_switch,
   input  logic brake,
   output logic fuel_pump_power
);

   import antitheft_pkg::*;

   fuel_state_t state;
   fuel_state_t next_state;

   always_comb
   begin
      next_state = state;
      case (state)
         pump_off:
            if (ignition) next_state = restore_start;
         restore_start:
         begin
            // hidden switch with brake held is the unlock
            if (!ignition)
               next_state = pump_off;
            else if (hidden_switch && brake)
               next_state = restore;
         end
         restore:
            next_state = latch_on;
         default:
            if (!ignition) next_state = pump_off;
      endcase
   end

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         state           <= pump_off;
         fuel_pump_power <= 1'b0;
      end
      else
      begin
         state           <= next_state;
         fuel_pump_power <= (next_state == restore) || (next_state == latch_on);
      end
   end

endmodule

// File: source/input_conditioner.sv
`timescale 1ns/10ps

module input_conditioner
(
   input  logic                                   clock_25mhz,
   input  logic [antitheft_pkg::NUM_SWITCHES-1:0] raw_switches,
   output logic [antitheft_pkg::NUM_SWITCHES-1:0] synced_switches
);

   import antitheft_pkg::*;

   // first stage may go metastable
   logic [NUM_SWITCHES-1:0] sync_stage;

   ////////////////////////////////////////
   // two-flop synchronizer per bit
   ////////////////////////////////////////
   always_ff @(posedge clock_25mhz)
   begin
      sync_stage      <= raw_switches;
      synced_switches <= sync_stage;
   end

endmodule

// File: source/interval_timer.sv
`timescale 1ns/10ps

module interval_timer
#(
   parameter int TICKS_PER_SECOND = 25_000_000
)
(
   input  logic                                 clock_25mhz,
   input  logic                                 reset_sync,
   input  logic                                 start_timer,
   input  logic [antitheft_pkg::TIME_WIDTH-1:0] load_value,
   output logic                                 second_tick,
   output logic                                 expired,
   output logic [antitheft_pkg::TIME_WIDTH-1:0] countdown
);

   import antitheft_pkg::*;

   localparam int DIV_WIDTH = $clog2(TICKS_PER_SECOND + 1);

   logic [DIV_WIDTH-1:0] div_count;
   // high between a start and its expiry
   logic                 running;

   ////////////////////////////////////////
   // one-second divider, realigned on start
   ////////////////////////////////////////
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync || start_timer)
      begin
         div_count   <= '0;
         second_tick <= 1'b0;
      end
      else if (div_count == DIV_WIDTH'(TICKS_PER_SECOND - 1))
      begin
         div_count   <= '0;
         second_tick <= 1'b1;
      end
      else
      begin
         div_count   <= div_count + 1'b1;
         second_tick <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // countdown
   ////////////////////////////////////////
   always_ff @(posedge clock_25mhz)
   begin
      expired <= 1'b0;
      if (reset_sync)
      begin
         countdown <= '0;
         running   <= 1'b0;
      end
      else if (start_timer)
      begin
         countdown <= load_value;
         running   <= 1'b1;
      end
      else if (second_tick && running)
      begin
         if (countdown == '0)
         begin
            // first tick at zero ends the interval
            expired <= 1'b1;
            running <= 1'b0;
         end
         else
         begin
            countdown <= countdown - TIME_WIDTH'(1);
         end
      end
   end

endmodule

// File: source/switch_debounce.sv
`timescale 1ns/10ps

module switch_debounce
#(
   parameter int DEBOUNCE_CYCLES = 250_000
)
(
   input  logic clock_25mhz,
   input  logic reset_sync,
   input  logic noisy,
   output logic clean
);

   localparam int COUNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

   // last sampled level and how long it has held
   logic                   sampled;
   logic [COUNT_WIDTH-1:0] stable_count;

   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         sampled      <= noisy;
         clean        <= noisy;
         stable_count <= '0;
      end
      else if (noisy != sampled)
      begin
         // any bounce restarts the count
         sampled      <= noisy;
         stable_count <= '0;
      end
      else if (stable_count == COUNT_WIDTH'(DEBOUNCE_CYCLES))
      begin
         clean <= sampled;
      end
      else
      begin
         stable_count <= stable_count + 1'b1;
      end
   end

endmodule

// File: source/time_parameter_store.sv
`timescale 1ns/10ps

module time_parameter_store
(
   input  logic                                 clock_25mhz,
   input  logic                                 reset_sync,
   input  logic                                 reprogram,
   input  logic [1:0]                           select,
   input  logic [antitheft_pkg::TIME_WIDTH-1:0] new_value,
   input  logic [1:0]                           interval,
   output logic [antitheft_pkg::TIME_WIDTH-1:0] selected_time
);

   import antitheft_pkg::*;

   time_parameters_t parameters;

   ////////////////////////////////////////
   // parameter register
   ////////////////////////////////////////
   always_ff @(posedge clock_25mhz)
   begin
      if (reset_sync)
      begin
         // whole word at once
         parameters.word <= DEFAULT_PARAMETERS;
      end
      else if (reprogram)
      begin
         parameters.field[select] <= new_value;
      end
   end

   // read side follows interval directly
   // so the timer loads it with start_timer
   assign selected_time = parameters.field[interval];

endmodule

// File: tb.f
source/antitheft_pkg.sv
source/input_conditioner.sv
source/switch_debounce.sv
source/interval_timer.sv
source/time_parameter_store.sv
source/anti_theft_fsm.sv
source/fuel_pump_fsm.sv
source/anti_theft_top.sv
verif/anti_theft_sva.sv
verif/anti_theft_tb.sv

// File: verif/anti_theft_sva.sv
`timescale 1ns/10ps

module anti_theft_sva
(
   input logic clock_25mhz,
   input logic reset_sync,
   input logic start_timer,
   input logic alarm,
   input logic status_lamp
);

   ////////////////////////////////////////
   // anti-theft FSM properties
   ////////////////////////////////////////
   // alarm states drive the lamp steady on
   alarm_lamp_steady: assert property (@(posedge clock_25mhz) disable iff (reset_sync)
      alarm |-> status_lamp)
      else $error("alarm is high while the status lamp is dark");

   timer_start_pulse: assert property (@(posedge clock_25mhz) disable iff (reset_sync)
      start_timer |=> !start_timer)
      else $error("start_timer stayed high for more than one cycle");

   // no alarm right out of reset
   alarm_low_after_reset: assert property (@(posedge clock_25mhz)
      reset_sync |=> !alarm)
      else $error("alarm is high in the cycle after reset");

endmodule

bind anti_theft_fsm anti_theft_sva anti_theft_sva_inst
(
   .clock_25mhz(clock_25mhz),
   .reset_sync(reset_sync),
   .start_timer(start_timer),
   .alarm(alarm),
   .status_lamp(status_lamp)
);

// File: verif/anti_theft_tb.sv
`timescale 1ns/10ps

module anti_theft_tb;

   import antitheft_pkg::*;

   localparam int TICKS_PER_SECOND = 16;
   localparam int DEBOUNCE_CYCLES  = 4;
   // longer than a blink half period of one second
   localparam int HOLD_CYCLES      = 24;

   // row checks
   localparam logic [1:0] CHECK_REACH = 2'd0;
   localparam logic [1:0] CHECK_HOLD  = 2'd1;
   localparam logic [1:0] CHECK_BLINK = 2'd2;

   // watched outputs
   localparam logic [1:0] SIG_ALARM = 2'd0;
   localparam logic [1:0] SIG_LAMP  = 2'd1;
   localparam logic [1:0] SIG_FUEL  = 2'd2;

   typedef struct packed {
      logic [5:0]            buttons;
      logic [1:0]            select;
      logic [TIME_WIDTH-1:0] value;
      logic                  restart;
      logic [1:0]            check;
      logic [1:0]            watch;
      logic                  target;
      int                    min_s;
      int                    max_s;
   } scenario_t;

   logic                  clock_25mhz;
   logic                  reset_sync;
   logic                  brake_button;
   logic                  hidden_button;
   logic                  driver_door_button;
   logic                  passenger_door_button;
   logic                  ignition_switch;
   logic                  reprogram_button;
   logic [1:0]            select_switches;
   logic [TIME_WIDTH-1:0] value_switches;
   logic                  alarm;
   logic                  status_lamp;
   logic                  fuel_pump_power;
   logic [TIME_WIDTH-1:0] countdown;

   int        cycle_count = 0;
   scenario_t scenarios[$];
   string     row_names[$];

   anti_theft_top #(.TICKS_PER_SECOND(TICKS_PER_SECOND), .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES))
   anti_theft_top_inst
   (
      .clock_25mhz, .reset_sync, .brake_button, .hidden_button, .driver_door_button,
      .passenger_door_button, .ignition_switch, .reprogram_button, .select_switches,
      .value_switches, .alarm, .status_lamp, .fuel_pump_power, .countdown
   );

   initial
   begin
      clock_25mhz = 1'b0;
      forever #20 clock_25mhz = ~clock_25mhz;
   end

   always @(posedge clock_25mhz)
      cycle_count <= cycle_count + 1;

   function automatic logic watched_level(input logic [1:0] watch);
      case (watch)
         SIG_ALARM: return alarm;
         SIG_LAMP:  return status_lamp;
         default:   return fuel_pump_power;
      endcase
   endfunction

   function automatic string output_name(input logic [1:0] watch);
      case (watch)
         SIG_ALARM: return "alarm";
         SIG_LAMP:  return "status_lamp";
         default:   return "fuel_pump_power";
      endcase
   endfunction

   task automatic add_row(input string name, input logic [5:0] buttons, input logic [1:0] select,
                          input logic [TIME_WIDTH-1:0] value, input logic restart,
                          input logic [1:0] check, input logic [1:0] watch, input logic target,
                          input int min_s, input int max_s);
      scenario_t row;
      row.buttons = buttons;
      row.select  = select;
      row.value   = value;
      row.restart = restart;
      row.check   = check;
      row.watch   = watch;
      row.target  = target;
      row.min_s   = min_s;
      row.max_s   = max_s;
      scenarios.push_back(row);
      row_names.push_back(name);
   endtask

   ////////////////////////////////////////
   // scenario table
   ////////////////////////////////////////
   task automatic fill_table();
      // buttons are ignition, driver, passenger, hidden, brake, reprogram
      // then select, value, restart timing, check, output, level, min s, max s
      add_row("reset, alarm low", 6'b000000, 2'd0, 4'd0, 1'b1, CHECK_HOLD, SIG_ALARM, 1'b0, 0, 2);
      add_row("reset, pump off", 6'b000000, 2'd0, 4'd0, 1'b1, CHECK_HOLD, SIG_FUEL, 1'b0, 0, 2);
      add_row("reset, lamp blinks", 6'b000000, 2'd0, 4'd0, 1'b1, CHECK_BLINK, SIG_LAMP, 1'b0, 0, 3);
      add_row("driver door, lamp steady", 6'b010000, 2'd0, 4'd0, 1'b1, CHECK_HOLD, SIG_LAMP,
              1'b1, 0, 3);
      // driver delay 8 timed from the door opening
      add_row("driver delay, alarm on", 6'b010000, 2'd0, 4'd0, 1'b0, CHECK_REACH, SIG_ALARM,
              1'b1, 8, 10);
      // alarm-on time 10
      add_row("doors closed, alarm off", 6'b000000, 2'd0, 4'd0, 1'b1, CHECK_REACH, SIG_ALARM,
              1'b0, 11, 12);
      add_row("alarm over, lamp blinks", 6'b000000, 2'd0, 4'd0, 1'b1, CHECK_BLINK, SIG_LAMP,
              1'b0, 0, 3);
      add_row("ignition, lamp off", 6'b100000, 2'd0, 4'd0, 1'b1, CHECK_HOLD, SIG_LAMP, 1'b0, 0, 3);
      add_row("ignition off, door open", 6'b010000, 2'd0, 4'd0, 1'b1, CHECK_HOLD, SIG_LAMP,
              1'b0, 0, 3);
      // arm delay 6 expires, then the next tick shows the blink
      add_row("door shut, rearming", 6'b000000, 2'd0, 4'd0, 1'b1, CHECK_BLINK, SIG_LAMP,
              1'b0, 7, 9);
      add_row("reprogram passenger delay", 6'b000001, 2'd2, 4'd2, 1'b1, CHECK_HOLD, SIG_LAMP,
              1'b0, 0, 3);
      add_row("reprogram released", 6'b000000, 2'd2, 4'd2, 1'b1, CHECK_BLINK, SIG_LAMP,
              1'b0, 0, 3);
      add_row("passenger door, alarm on", 6'b001000, 2'd2, 4'd2, 1'b1, CHECK_REACH, SIG_ALARM,
              1'b1, 2, 4);
      add_row("ignition, alarm cleared", 6'b101000, 2'd2, 4'd2, 1'b1, CHECK_REACH, SIG_ALARM,
              1'b0, 0, 1);
      add_row("ignition alone, pump off", 6'b100000, 2'd2, 4'd2, 1'b1, CHECK_HOLD, SIG_FUEL,
              1'b0, 0, 2);
      add_row("hidden and brake, pump on", 6'b100110, 2'd2, 4'd2, 1'b1, CHECK_REACH, SIG_FUEL,
              1'b1, 0, 1);
      add_row("ignition off, pump off", 6'b000000, 2'd2, 4'd2, 1'b1, CHECK_REACH, SIG_FUEL,
              1'b0, 0, 1);
   endtask

   // waits for the row's event, then checks when it came
   task automatic run_row(input scenario_t row, input string name, input int ref_cycle,
                          output bit ok);
      int   n;
      int   limit;
      int   held;
      int   event_cycle;
      logic start_level;
      bit   seen;
      ok          = 1'b1;
      seen        = 1'b0;
      held        = 0;
      event_cycle = 0;
      start_level = watched_level(row.watch);
      limit       = row.max_s * TICKS_PER_SECOND - (cycle_count - ref_cycle);
      for (n = 0; n < limit && !seen; n++)
      begin
         @(negedge clock_25mhz);
         if (row.check == CHECK_BLINK)
            seen = (watched_level(row.watch) != start_level);
         else if (watched_level(row.watch) == row.target)
         begin
            held++;
            seen = (row.check == CHECK_REACH) || (held == HOLD_CYCLES);
         end
         else
            held = 0;
      end
      if (!seen)
      begin
         $display("%s: timed out after %0d s waiting for %s", name, row.max_s,
                  output_name(row.watch));
         ok = 1'b0;
      end
      else
      begin
         event_cycle = (row.check == CHECK_HOLD) ? cycle_count - HOLD_CYCLES + 1 : cycle_count;
         if (event_cycle - ref_cycle < row.min_s * TICKS_PER_SECOND)
         begin
            $display("error at time %0t: %s, %s changed after %0d cycles, before %0d s",
                     $time, name, output_name(row.watch), event_cycle - ref_cycle, row.min_s);
            ok = 1'b0;
         end
         // timed events follow an expiry, which leaves the count at zero
         if (row.min_s > 0 && countdown != '0)
         begin
            $display("error at time %0t: %s, countdown reads %0d after the interval ran out",
                     $time, name, countdown);
            ok = 1'b0;
         end
      end
      // a blink needs a second edge about one second later
      if (seen && row.check == CHECK_BLINK)
      begin
         seen        = 1'b0;
         start_level = watched_level(row.watch);
         for (n = 0; n < HOLD_CYCLES && !seen; n++)
         begin
            @(negedge clock_25mhz);
            seen = (watched_level(row.watch) != start_level);
         end
         if (!seen)
         begin
            $display("%s: timed out waiting for the lamp's second blink edge", name);
            ok = 1'b0;
         end
         else if (cycle_count - event_cycle < TICKS_PER_SECOND / 2)
         begin
            $display("error at time %0t: %s, lamp toggled again after %0d cycles",
                     $time, name, cycle_count - event_cycle);
            ok = 1'b0;
         end
      end
   endtask

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////
   initial
   begin : main_sequence
      int        i;
      int        passed;
      int        failed;
      int        ref_cycle;
      bit        ok;
      scenario_t row;
      passed    = 0;
      failed    = 0;
      ref_cycle = 0;
      reset_sync = 1'b1;
      {ignition_switch, driver_door_button, passenger_door_button} = 3'b000;
      {hidden_button, brake_button, reprogram_button} = 3'b000;
      select_switches = 2'd0;
      value_switches  = '0;
      fill_table();
      repeat (10) @(negedge clock_25mhz);
      reset_sync = 1'b0;
      for (i = 0; i < scenarios.size(); i++)
      begin
         row = scenarios[i];
         @(negedge clock_25mhz);
         {ignition_switch, driver_door_button, passenger_door_button,
          hidden_button, brake_button, reprogram_button} = row.buttons;
         select_switches = row.select;
         value_switches  = row.value;
         if (row.restart)
            ref_cycle = cycle_count;
         run_row(row, row_names[i], ref_cycle, ok);
         if (ok)
            passed++;
         else
            failed++;
         $display("row %0d %s: %s", i, row_names[i], ok ? "ok" : "failed");
      end
      $display("%0d rows run, %0d passed, %0d failed", scenarios.size(), passed, failed);
      if (failed == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule
